/* hw/cam_init_pkg.sv */
package cam_init_pkg;

  // **************************************************
  // Bus widths
  // **************************************************

  localparam int SENSOR_ADDR_W = 16;
  localparam int SENSOR_DATA_W = 8;
  localparam int CSR_ADDR_W    = 8;
  localparam int CSR_DATA_W    = 32;

  // One sensor register write, address in the upper bits.
  typedef struct packed {
    logic [SENSOR_ADDR_W-1:0] addr;
    logic [SENSOR_DATA_W-1:0] data;
  } sensor_cmd_t;

  // **************************************************
  // Sensor command tables
  // **************************************************

  localparam int INIT_OPS_NUM = 8;
  localparam int MODE_OPS_NUM = 6;

  // Common init sequence.
  localparam sensor_cmd_t INIT_ROM [INIT_OPS_NUM] = '{
    '{16'h0136, 8'h18},  // External clock, integer part.
    '{16'h0137, 8'h00},
    '{16'he000, 8'h00},
    '{16'he07a, 8'h01},
    '{16'h0808, 8'h02},  // MIPI timing, manual mode.
    '{16'h4ae9, 8'h18},
    '{16'h4aea, 8'h08},
    '{16'hf61c, 8'h04}
  };

  // 1080p30 mode.
  localparam sensor_cmd_t MODE_ROM [MODE_OPS_NUM] = '{
    '{16'h0112, 8'h0a},  // RAW10 in and out.
    '{16'h0113, 8'h0a},
    '{16'h0114, 8'h01},  // Two data lanes.
    '{16'h0342, 8'h31},  // Line length.
    '{16'h0343, 8'hc4},
    '{16'h0340, 8'h0b}   // Frame length, high byte.
  };

  // **************************************************
  // Receiver CSR writes
  // **************************************************

  localparam logic [CSR_ADDR_W-1:0] CSR_SLAVE_ADDR_REG = 8'h08;
  localparam logic [CSR_DATA_W-1:0] CSR_SLAVE_ADDR_VAL = 32'h1a;
  localparam logic [CSR_ADDR_W-1:0] CSR_DPHY_RUN_REG   = 8'h04;
  localparam logic [CSR_DATA_W-1:0] CSR_DPHY_RUN_VAL   = 32'h1;

endpackage

/* hw/reg_wr_if.sv */
`timescale 1ns/1ps

// Single register write request with completion pulse.
interface reg_wr_if #(
  parameter type addr_t = logic [15:0],
  parameter type data_t = logic [7:0]
);

  addr_t addr;
  data_t data;
  logic  wr_stb;  // Held while a write is pending.
  logic  done;    // One cycle per completed write.

  modport req (
    output addr,
    output data,
    output wr_stb,
    input  done
  );

  modport srv (
    input  addr,
    input  data,
    input  wr_stb,
    output done
  );

endinterface

/* hw/cam_rst_sync.sv */
`timescale 1ns/1ps

module cam_rst_sync (
  input  logic clk_i,
  input  logic rst_i,
  input  logic rst_req_i,
  output logic rst_stb_o
);

logic req_meta;
logic req_sync;
logic req_sync_d;

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    begin
      req_meta   <= 1'b0;
      req_sync   <= 1'b0;
      req_sync_d <= 1'b0;
      rst_stb_o  <= 1'b0;
    end
  else
    begin
      req_meta   <= rst_req_i;
      req_sync   <= req_meta;
      req_sync_d <= req_sync;
      rst_stb_o  <= req_sync && !req_sync_d;  // Rising edge only.
    end

a_stb_single : assert property ( @( posedge clk_i ) disable iff ( rst_i )
  rst_stb_o |=> !rst_stb_o );

endmodule

/* hw/cam_pwup_seq.sv */
`timescale 1ns/1ps

module cam_pwup_seq #(
  parameter int CLK_FREQ = 74_250_000
)(
  input  logic   clk_i,
  input  logic   rst_i,
  input  logic   cam_rst_stb_i,
  output logic   cam_pwup_o,
  output logic   init_done_o,
  reg_wr_if.req  sensor_wr,
  reg_wr_if.req  csr_wr
);

localparam int TICKS_100MS = int'( 64'( CLK_FREQ ) / 64'd10 );
localparam int TICKS_150MS = int'( ( 64'( CLK_FREQ ) * 64'd3 ) / 64'd20 );
localparam int CNT_W       = $clog2( TICKS_150MS + 1 );
localparam int INIT_IDX_W  = $clog2( cam_init_pkg::INIT_OPS_NUM );
localparam int MODE_IDX_W  = $clog2( cam_init_pkg::MODE_OPS_NUM );

localparam logic [INIT_IDX_W-1:0] INIT_LAST = INIT_IDX_W'( cam_init_pkg::INIT_OPS_NUM - 1 );
localparam logic [MODE_IDX_W-1:0] MODE_LAST = MODE_IDX_W'( cam_init_pkg::MODE_OPS_NUM - 1 );

logic [CNT_W-1:0]          pwup_cnt;
logic [INIT_IDX_W-1:0]     init_idx;
logic [MODE_IDX_W-1:0]     mode_idx;
logic                      restart;
cam_init_pkg::sensor_cmd_t sensor_cmd;

typedef enum logic [2:0] {
  PWUP_WAIT_S,
  SET_SLAVE_ADDR_S,
  CFG_INIT_S,
  SET_MODE_S,
  RUN_DPHY_S,
  RUN_S
} state_t;

state_t state, next_state;

assign restart = ( state == RUN_S ) && cam_rst_stb_i;

// **************************************************
// Sequencing FSM
// **************************************************

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    state <= PWUP_WAIT_S;
  else
    state <= next_state;

always_comb
  begin
    next_state = state;
    case( state )
      PWUP_WAIT_S:
        if( pwup_cnt == CNT_W'( TICKS_150MS ) )
          next_state = SET_SLAVE_ADDR_S;
      SET_SLAVE_ADDR_S:
        if( csr_wr.done )
          next_state = CFG_INIT_S;
      CFG_INIT_S:
        if( sensor_wr.done && init_idx == INIT_LAST )
          next_state = SET_MODE_S;
      SET_MODE_S:
        if( sensor_wr.done && mode_idx == MODE_LAST )
          next_state = RUN_DPHY_S;
      RUN_DPHY_S:
        if( csr_wr.done )
          next_state = RUN_S;
      RUN_S:
        if( cam_rst_stb_i )
          next_state = PWUP_WAIT_S;
      default:
        next_state = PWUP_WAIT_S;
    endcase
  end

// **************************************************
// Power-up timer and table indexes
// **************************************************

// Saturates at 150 ms.
always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    pwup_cnt <= '0;
  else if( restart )
    pwup_cnt <= '0;
  else if( pwup_cnt < CNT_W'( TICKS_150MS ) )
    pwup_cnt <= pwup_cnt + 1'b1;

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    init_idx <= '0;
  else if( restart )
    init_idx <= '0;
  else if( state == CFG_INIT_S && sensor_wr.done )
    init_idx <= ( init_idx == INIT_LAST ) ? '0 : init_idx + 1'b1;

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    mode_idx <= '0;
  else if( restart )
    mode_idx <= '0;
  else if( state == SET_MODE_S && sensor_wr.done )
    mode_idx <= ( mode_idx == MODE_LAST ) ? '0 : mode_idx + 1'b1;

// **************************************************
// Write requests
// **************************************************

always_comb
  case( state )
    CFG_INIT_S: sensor_cmd = cam_init_pkg::INIT_ROM[init_idx];
    SET_MODE_S: sensor_cmd = cam_init_pkg::MODE_ROM[mode_idx];
    default:    sensor_cmd = '0;
  endcase

assign sensor_wr.addr   = sensor_cmd.addr;
assign sensor_wr.data   = sensor_cmd.data;
assign sensor_wr.wr_stb = ( state == CFG_INIT_S ) || ( state == SET_MODE_S );

always_comb
  case( state )
    SET_SLAVE_ADDR_S:
      begin
        csr_wr.addr = cam_init_pkg::CSR_SLAVE_ADDR_REG;
        csr_wr.data = cam_init_pkg::CSR_SLAVE_ADDR_VAL;
      end
    RUN_DPHY_S:
      begin
        csr_wr.addr = cam_init_pkg::CSR_DPHY_RUN_REG;
        csr_wr.data = cam_init_pkg::CSR_DPHY_RUN_VAL;
      end
    default:
      begin
        csr_wr.addr = '0;
        csr_wr.data = '0;
      end
  endcase

assign csr_wr.wr_stb = ( state == SET_SLAVE_ADDR_S ) || ( state == RUN_DPHY_S );

assign init_done_o = ( state == RUN_S );
assign cam_pwup_o  = ( pwup_cnt >= CNT_W'( TICKS_100MS ) );

// Only one bus is busy at a time.
a_one_bus : assert property ( @( posedge clk_i ) disable iff ( rst_i )
  !( sensor_wr.wr_stb && csr_wr.wr_stb ) );

a_sensor_hold : assert property ( @( posedge clk_i ) disable iff ( rst_i )
  sensor_wr.wr_stb && !sensor_wr.done |=> $stable( sensor_wr.addr ) );

a_csr_hold : assert property ( @( posedge clk_i ) disable iff ( rst_i )
  csr_wr.wr_stb && !csr_wr.done |=> $stable( csr_wr.addr ) );

endmodule

/* hw/reg_wr_master.sv */
`timescale 1ns/1ps

module reg_wr_master #(
  parameter type addr_t = logic [7:0],
  parameter type data_t = logic [31:0]
)(
  input  logic  clk_i,
  input  logic  rst_i,
  reg_wr_if.srv req,
  output addr_t awaddr_o,
  output logic  awvalid_o,
  input  logic  awready_i,
  output data_t wdata_o,
  output logic  wvalid_o,
  input  logic  wready_i,
  input  logic  bvalid_i,
  output logic  bready_o
);

logic  aw_busy;
logic  w_busy;
logic  b_busy;
logic  idle;
logic  start;
logic  aw_hs;
logic  w_hs;
logic  both_acc;
addr_t addr_q;
data_t data_q;

assign idle  = !aw_busy && !w_busy && !b_busy;
assign start = idle && req.wr_stb;

assign aw_hs = aw_busy && awready_i;
assign w_hs  = w_busy && wready_i;

// Last outstanding channel is accepted this cycle.
assign both_acc = ( aw_busy || w_busy ) &&
                  ( !aw_busy || awready_i ) &&
                  ( !w_busy  || wready_i  );

// **************************************************
// Request latch
// **************************************************

always_ff @( posedge clk_i )
  if( start )
    begin
      addr_q <= req.addr;
      data_q <= req.data;
    end

// **************************************************
// AXI4-Lite write channels
// **************************************************

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    aw_busy <= 1'b0;
  else if( start )
    aw_busy <= 1'b1;
  else if( aw_hs )
    aw_busy <= 1'b0;

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    w_busy <= 1'b0;
  else if( start )
    w_busy <= 1'b1;
  else if( w_hs )
    w_busy <= 1'b0;

// Response phase.
always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    b_busy <= 1'b0;
  else if( both_acc )
    b_busy <= 1'b1;
  else if( req.done )
    b_busy <= 1'b0;

assign awaddr_o  = addr_q;
assign awvalid_o = aw_busy;
assign wdata_o   = data_q;
assign wvalid_o  = w_busy;
assign bready_o  = b_busy;
assign req.done  = b_busy && bvalid_i;  // Write response accepted.

a_aw_stable : assert property ( @( posedge clk_i ) disable iff ( rst_i )
  awvalid_o && !awready_i |=> awvalid_o && $stable( awaddr_o ) );

a_w_stable : assert property ( @( posedge clk_i ) disable iff ( rst_i )
  wvalid_o && !wready_i |=> wvalid_o && $stable( wdata_o ) );

endmodule

/* hw/cam_ctrl_top.sv */
`timescale 1ns/1ps

module cam_ctrl_top #(
  parameter int CLK_FREQ = 74_250_000
)(
  input  logic                                    clk_i,
  input  logic                                    rst_i,
  input  logic                                    cam_rst_req_i,
  output logic                                    cam_pwup_o,
  output logic                                    init_done_o,
  // Sensor register bus.
  output logic [cam_init_pkg::SENSOR_ADDR_W-1:0]  sensor_awaddr_o,
  output logic                                    sensor_awvalid_o,
  input  logic                                    sensor_awready_i,
  output logic [cam_init_pkg::SENSOR_DATA_W-1:0]  sensor_wdata_o,
  output logic                                    sensor_wvalid_o,
  input  logic                                    sensor_wready_i,
  input  logic                                    sensor_bvalid_i,
  output logic                                    sensor_bready_o,
  // Receiver CSR bus.
  output logic [cam_init_pkg::CSR_ADDR_W-1:0]     csr_awaddr_o,
  output logic                                    csr_awvalid_o,
  input  logic                                    csr_awready_i,
  output logic [cam_init_pkg::CSR_DATA_W-1:0]     csr_wdata_o,
  output logic                                    csr_wvalid_o,
  input  logic                                    csr_wready_i,
  input  logic                                    csr_bvalid_i,
  output logic                                    csr_bready_o
);

logic cam_rst_stb;

reg_wr_if #(
  .addr_t ( logic [cam_init_pkg::SENSOR_ADDR_W-1:0] ),
  .data_t ( logic [cam_init_pkg::SENSOR_DATA_W-1:0] )
) sensor_wr ();

reg_wr_if #(
  .addr_t ( logic [cam_init_pkg::CSR_ADDR_W-1:0] ),
  .data_t ( logic [cam_init_pkg::CSR_DATA_W-1:0] )
) csr_wr ();

cam_rst_sync u_rst_sync (
  .clk_i     ( clk_i         ),
  .rst_i     ( rst_i         ),
  .rst_req_i ( cam_rst_req_i ),
  .rst_stb_o ( cam_rst_stb   )
);

cam_pwup_seq #(
  .CLK_FREQ      ( CLK_FREQ        )
) u_pwup_seq (
  .clk_i         ( clk_i           ),
  .rst_i         ( rst_i           ),
  .cam_rst_stb_i ( cam_rst_stb     ),
  .cam_pwup_o    ( cam_pwup_o      ),
  .init_done_o   ( init_done_o     ),
  .sensor_wr     ( sensor_wr.req   ),
  .csr_wr        ( csr_wr.req      )
);

reg_wr_master #(
  .addr_t    ( logic [cam_init_pkg::SENSOR_ADDR_W-1:0] ),
  .data_t    ( logic [cam_init_pkg::SENSOR_DATA_W-1:0] )
) u_sensor_master (
  .clk_i     ( clk_i            ),
  .rst_i     ( rst_i            ),
  .req       ( sensor_wr.srv    ),
  .awaddr_o  ( sensor_awaddr_o  ),
  .awvalid_o ( sensor_awvalid_o ),
  .awready_i ( sensor_awready_i ),
  .wdata_o   ( sensor_wdata_o   ),
  .wvalid_o  ( sensor_wvalid_o  ),
  .wready_i  ( sensor_wready_i  ),
  .bvalid_i  ( sensor_bvalid_i  ),
  .bready_o  ( sensor_bready_o  )
);

reg_wr_master #(
  .addr_t    ( logic [cam_init_pkg::CSR_ADDR_W-1:0] ),
  .data_t    ( logic [cam_init_pkg::CSR_DATA_W-1:0] )
) u_csr_master (
  .clk_i     ( clk_i         ),
  .rst_i     ( rst_i         ),
  .req       ( csr_wr.srv    ),
  .awaddr_o  ( csr_awaddr_o  ),
  .awvalid_o ( csr_awvalid_o ),
  .awready_i ( csr_awready_i ),
  .wdata_o   ( csr_wdata_o   ),
  .wvalid_o  ( csr_wvalid_o  ),
  .wready_i  ( csr_wready_i  ),
  .bvalid_i  ( csr_bvalid_i  ),
  .bready_o  ( csr_bready_o  )
);

endmodule

/* testbench/tb_cam_ctrl_top.sv */
`timescale 1ns/1ps

// AXI4-Lite write slave with random ready and response delays.
module axi_wr_responder #(
  parameter int AW = 8,
  parameter int DW = 32
)(
  input  logic          clk_i,
  input  logic          rst_i,
  input  logic [AW-1:0] awaddr_i,
  input  logic          awvalid_i,
  output logic          awready_o,
  input  logic [DW-1:0] wdata_i,
  input  logic          wvalid_i,
  output logic          wready_o,
  output logic          bvalid_o,
  input  logic          bready_i,
  output logic          done_o,
  output logic [31:0]   addr_o,
  output logic [31:0]   data_o,
  output int            err_cnt_o
);

int   aw_dly;
int   w_dly;
int   b_dly;
int   err_cnt = 0;
logic aw_acc;
logic w_acc;

assign done_o    = bvalid_o && bready_i;
assign err_cnt_o = err_cnt;

task automatic report_fail( input string msg );
  err_cnt = err_cnt + 1;
  $display( "Fail %0t: %m %s", $time, msg );
endtask

initial
  begin
    awready_o = 1'b0;
    wready_o  = 1'b0;
    bvalid_o  = 1'b0;
    aw_dly    = 0;
    w_dly     = 0;
    b_dly     = 0;
    forever
      begin
        @( negedge clk_i );
        if( rst_i )
          begin
            awready_o = 1'b0;
            wready_o  = 1'b0;
            bvalid_o  = 1'b0;
          end
        else
          begin
            // A ready seen high at the last rising edge has completed its handshake.
            if( awready_o )
              begin
                awready_o = 1'b0;
                aw_dly    = $urandom % 4;
              end
            else if( awvalid_i )
              begin
                if( aw_dly == 0 )
                  awready_o = 1'b1;
                else
                  aw_dly = aw_dly - 1;
              end
            if( wready_o )
              begin
                wready_o = 1'b0;
                w_dly    = $urandom % 4;
              end
            else if( wvalid_i )
              begin
                if( w_dly == 0 )
                  wready_o = 1'b1;
                else
                  w_dly = w_dly - 1;
              end
            if( bvalid_o )
              begin
                bvalid_o = 1'b0;
                b_dly    = $urandom % 4;
              end
            else if( bready_i )
              begin
                if( b_dly == 0 )
                  bvalid_o = 1'b1;
                else
                  b_dly = b_dly - 1;
              end
          end
      end
  end

// Accepted payloads, kept until the response.
always @( posedge clk_i, posedge rst_i )
  if( rst_i )
    begin
      aw_acc <= 1'b0;
      w_acc  <= 1'b0;
      addr_o <= '0;
      data_o <= '0;
    end
  else
    begin
      if( awvalid_i && awready_o )
        begin
          aw_acc <= 1'b1;
          addr_o <= 32'( awaddr_i );
        end
      if( wvalid_i && wready_o )
        begin
          w_acc  <= 1'b1;
          data_o <= 32'( wdata_i );
        end
      if( done_o )
        begin
          aw_acc <= 1'b0;
          w_acc  <= 1'b0;
        end
    end

a_aw_hold : assert property ( @( posedge clk_i ) disable iff ( rst_i )
  awvalid_i && !awready_o |=> awvalid_i && $stable( awaddr_i ) )
  else report_fail( "awvalid or awaddr changed before awready" );

a_w_hold : assert property ( @( posedge clk_i ) disable iff ( rst_i )
  wvalid_i && !wready_o |=> wvalid_i && $stable( wdata_i ) )
  else report_fail( "wvalid or wdata changed before wready" );

a_b_order : assert property ( @( posedge clk_i ) disable iff ( rst_i )
  bready_i |-> aw_acc && w_acc )
  else report_fail( "bready high before address and data were accepted" );

endmodule

module tb_cam_ctrl_top;

localparam int CLK_FREQ    = 10_000;
localparam int CLK_PERIOD  = 4;
localparam int TICKS_100MS = CLK_FREQ * 100 / 1000;
localparam int TICKS_150MS = CLK_FREQ * 150 / 1000;
localparam int INIT_N      = cam_init_pkg::INIT_OPS_NUM;
localparam int MODE_N      = cam_init_pkg::MODE_OPS_NUM;
localparam int NUM_STEPS   = INIT_N + MODE_N + 2;
localparam int SEQ_CYCLES  = TICKS_150MS + NUM_STEPS * 16 + 64;
localparam int WATCHDOG_NS = 2 * 2 * SEQ_CYCLES * CLK_PERIOD;

logic        clk_i;
logic        rst_i         = 1'b1;
logic        cam_rst_req_i = 1'b0;
logic        cam_pwup_o;
logic        init_done_o;
logic [15:0] sensor_awaddr;
logic [7:0]  sensor_wdata;
logic [7:0]  csr_awaddr;
logic [31:0] csr_wdata;
logic        sensor_awvalid, sensor_awready, sensor_wvalid, sensor_wready;
logic        sensor_bvalid, sensor_bready, csr_awvalid, csr_awready;
logic        csr_wvalid, csr_wready, csr_bvalid, csr_bready;
logic        s_done;
logic        c_done;
logic [31:0] s_addr, s_data, c_addr, c_data;
int          sensor_err, csr_err;
int          seq_err = 0;
int          since;     // Cycles since the power-up timer started.
int          step;      // Position in the expected write order.
int          runs;
logic        done_q;

// **************************************************
// Expected write order
// **************************************************

// Returns {bus, addr, data}; bus 0 is the sensor, 1 the CSR block, 2 none.
function automatic logic [65:0] exp_write( input int idx );
  if( idx == 0 )
    return { 2'd1, 32'( cam_init_pkg::CSR_SLAVE_ADDR_REG ), cam_init_pkg::CSR_SLAVE_ADDR_VAL };
  else if( idx <= INIT_N )
    return { 2'd0, 32'( cam_init_pkg::INIT_ROM[idx-1].addr ),
             32'( cam_init_pkg::INIT_ROM[idx-1].data ) };
  else if( idx <= INIT_N + MODE_N )
    return { 2'd0, 32'( cam_init_pkg::MODE_ROM[idx-INIT_N-1].addr ),
             32'( cam_init_pkg::MODE_ROM[idx-INIT_N-1].data ) };
  else if( idx == NUM_STEPS - 1 )
    return { 2'd1, 32'( cam_init_pkg::CSR_DPHY_RUN_REG ), cam_init_pkg::CSR_DPHY_RUN_VAL };
  return { 2'd2, 64'd0 };
endfunction

task automatic report_fail( input string msg );
  seq_err = seq_err + 1;
  $display( "Fail %0t: %s", $time, msg );
endtask

initial
  begin
    clk_i = 1'b0;
    forever #( CLK_PERIOD / 2 ) clk_i = ~clk_i;
  end

cam_ctrl_top #(
  .CLK_FREQ ( CLK_FREQ )
) i_cam_ctrl_top (
  .clk_i ( clk_i ), .rst_i ( rst_i ), .cam_rst_req_i ( cam_rst_req_i ),
  .cam_pwup_o ( cam_pwup_o ), .init_done_o ( init_done_o ),
  .sensor_awaddr_o ( sensor_awaddr ), .sensor_awvalid_o ( sensor_awvalid ),
  .sensor_awready_i ( sensor_awready ), .sensor_wdata_o ( sensor_wdata ),
  .sensor_wvalid_o ( sensor_wvalid ), .sensor_wready_i ( sensor_wready ),
  .sensor_bvalid_i ( sensor_bvalid ), .sensor_bready_o ( sensor_bready ),
  .csr_awaddr_o ( csr_awaddr ), .csr_awvalid_o ( csr_awvalid ),
  .csr_awready_i ( csr_awready ), .csr_wdata_o ( csr_wdata ),
  .csr_wvalid_o ( csr_wvalid ), .csr_wready_i ( csr_wready ),
  .csr_bvalid_i ( csr_bvalid ), .csr_bready_o ( csr_bready )
);

axi_wr_responder #( .AW ( 16 ), .DW ( 8 ) ) u_sensor_slave (
  .clk_i ( clk_i ), .rst_i ( rst_i ),
  .awaddr_i ( sensor_awaddr ), .awvalid_i ( sensor_awvalid ), .awready_o ( sensor_awready ),
  .wdata_i ( sensor_wdata ), .wvalid_i ( sensor_wvalid ), .wready_o ( sensor_wready ),
  .bvalid_o ( sensor_bvalid ), .bready_i ( sensor_bready ), .done_o ( s_done ),
  .addr_o ( s_addr ), .data_o ( s_data ), .err_cnt_o ( sensor_err )
);

axi_wr_responder #( .AW ( 8 ), .DW ( 32 ) ) u_csr_slave (
  .clk_i ( clk_i ), .rst_i ( rst_i ),
  .awaddr_i ( csr_awaddr ), .awvalid_i ( csr_awvalid ), .awready_o ( csr_awready ),
  .wdata_i ( csr_wdata ), .wvalid_i ( csr_wvalid ), .wready_o ( csr_wready ),
  .bvalid_o ( csr_bvalid ), .bready_i ( csr_bready ), .done_o ( c_done ),
  .addr_o ( c_addr ), .data_o ( c_data ), .err_cnt_o ( csr_err )
);

// Write log. A drop of init_done_o starts a new sequence.
always @( posedge clk_i, posedge rst_i )
  if( rst_i )
    begin
      since  <= 0;
      step   <= 0;
      runs   <= 0;
      done_q <= 1'b0;
    end
  else
    begin
      done_q <= init_done_o;
      if( init_done_o && !done_q )
        runs <= runs + 1;
      if( done_q && !init_done_o )
        begin
          since <= 1;
          step  <= 0;
        end
      else
        begin
          since <= since + 1;
          if( s_done || c_done )
            step <= step + 1;
        end
    end

// **************************************************
// Sequence checks
// **************************************************

a_pwup_time : assert property ( @( posedge clk_i ) disable iff ( rst_i )
  !( done_q && !init_done_o ) |-> cam_pwup_o == ( since >= TICKS_100MS ) )
  else report_fail( $sformatf( "cam_pwup_o is %b at cycle %0d", cam_pwup_o, since ) );

a_quiet_start : assert property ( @( posedge clk_i ) disable iff ( rst_i )
  since <= TICKS_150MS |-> !sensor_awvalid && !sensor_wvalid && !csr_awvalid && !csr_wvalid )
  else report_fail( $sformatf( "bus write started at cycle %0d", since ) );

a_sensor_write : assert property ( @( posedge clk_i ) disable iff ( rst_i )
  s_done |-> exp_write( step ) == { 2'd0, s_addr, s_data } )
  else report_fail( $sformatf( "unexpected sensor write %h=%h at step %0d",
                               s_addr, s_data, step ) );

a_csr_write : assert property ( @( posedge clk_i ) disable iff ( rst_i )
  c_done |-> exp_write( step ) == { 2'd1, c_addr, c_data } )
  else report_fail( $sformatf( "unexpected CSR write %h=%h at step %0d",
                               c_addr, c_data, step ) );

a_done_rise : assert property ( @( posedge clk_i ) disable iff ( rst_i )
  c_done && step == NUM_STEPS - 1 |=> init_done_o )
  else report_fail( "init_done_o did not rise after the D-PHY write" );

a_done_complete : assert property ( @( posedge clk_i ) disable iff ( rst_i )
  init_done_o |-> step == NUM_STEPS && !sensor_awvalid && !csr_awvalid )
  else report_fail( $sformatf( "init_done_o high at step %0d or with a write pending", step ) );

a_restart_drop : assert property ( @( posedge clk_i ) disable iff ( rst_i )
  $fell( init_done_o ) |-> !cam_pwup_o )
  else report_fail( "cam_pwup_o still high after init_done_o dropped" );

initial
  begin
    #( WATCHDOG_NS );
    $display( "Timeout: init sequence not finished after %0d ns", WATCHDOG_NS );
    $display( ">>> FAIL" );
    $finish;
  end

initial
  begin
    int total;
    void'( $urandom( 32'hbb74e5a0 ) );
    repeat( 10 ) @( negedge clk_i );
    rst_i = 1'b0;
    for( int run = 0; run < 2; run++ )
      begin
        while( !init_done_o ) @( negedge clk_i );
        repeat( 20 ) @( negedge clk_i );  // Bus must stay quiet here.
        if( run == 0 )
          begin
            cam_rst_req_i = 1'b1;
            while( init_done_o ) @( negedge clk_i );
            repeat( 4 ) @( negedge clk_i );
            cam_rst_req_i = 1'b0;
          end
      end
    total = seq_err + sensor_err + csr_err;
    $display( "Errors: %0d (sequence %0d, sensor bus %0d, CSR bus %0d), init runs %0d",
              total, seq_err, sensor_err, csr_err, runs );
    if( total == 0 )
      $display( ">>> PASS" );
    else
      $display( ">>> FAIL" );
    $finish;
  end

endmodule

/* cam_ctrl_top.f */
hw/cam_init_pkg.sv
hw/reg_wr_if.sv
hw/cam_rst_sync.sv
hw/cam_pwup_seq.sv
hw/reg_wr_master.sv
hw/cam_ctrl_top.sv
testbench/tb_cam_ctrl_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the camera init controller testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal -f cam_ctrl_top.f \
  --top-module tb_cam_ctrl_top -o tb_sim > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }

# Failure is decided from the log, not from the simulator's exit status.
(./obj_dir/tb_sim 2>&1 | tee sim.log) \
  && ! grep -q '>>> FAIL' sim.log \
  && grep -q '>>> PASS' sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
